// ==== mx_pkg.sv ====
package mx_pkg;

    // Block geometry
    localparam int block_size = 8;
    localparam int man_width  = 8;
    localparam int exp_width  = 8;

    // Skip FIFO must cover the processing skew
    localparam int fifo_depth = 8;

    // Magnitude bits of a mantissa, sign excluded
    localparam int mag_width  = man_width - 1;

    typedef logic signed [man_width-1:0]      mantissa_t;
    typedef logic [exp_width-1:0]             exponent_t;

    // Lane sum with one guard bit
    typedef logic signed [man_width:0]        sum_t;

    // Normalization shift, 0 up to mag_width
    typedef logic [$clog2(man_width)-1:0]     shift_t;

    typedef logic [$clog2(fifo_depth)-1:0]    fifo_ptr_t;
    typedef logic [$clog2(fifo_depth+1)-1:0]  fifo_count_t;

    // Saturation limits
    localparam mantissa_t man_max = {1'b0, {(man_width-1){1'b1}}};
    localparam mantissa_t man_min = {1'b1, {(man_width-1){1'b0}}};
    localparam exponent_t exp_max = '1;

    // Shared exponent on top, lane 0 in the low bits
    typedef struct packed {
        exponent_t                  exp;
        mantissa_t [block_size-1:0] man;
    } mx_block_t;

endpackage

// ==== mx_block_fifo.sv ====
`timescale 1ns/1ps

module mx_block_fifo (
    input  logic              clk,
    input  logic              rst,
    input  mx_pkg::mx_block_t in_block,
    input  logic              in_valid,
    output logic              in_ready,
    output mx_pkg::mx_block_t out_block,
    output logic              out_valid,
    input  logic              out_ready
);
    import mx_pkg::*;

    mx_block_t   mem [fifo_depth];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        push;
    logic        load_out;
    logic        bypass;
    logic        store;
    logic        pop;

    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        return (ptr == fifo_ptr_t'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready = (count != fifo_count_t'(fifo_depth));
    assign push     = in_valid && in_ready;

    // Output register is free when empty or read in this cycle
    assign load_out = !out_valid || out_ready;

    // Storage empty, so the new block goes straight to the output register
    assign bypass   = push && load_out && (count == '0);
    assign store    = push && !bypass;
    assign pop      = load_out && (count != '0);

    always_ff @(posedge clk) begin
        if (store) begin
            mem[wr_ptr] <= in_block;
        end
        if (bypass) begin
            out_block <= in_block;
        end else if (pop) begin
            out_block <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (store) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (store && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !store) begin
                count <= count - 1'b1;
            end
            if (load_out) begin
                out_valid <= bypass || pop;
            end
        end
    end

endmodule

// ==== mx_block_fork.sv ====
`timescale 1ns/1ps

module mx_block_fork (
    input  logic              clk,
    input  logic              rst,

    // Incoming blocks
    input  mx_pkg::mx_block_t in_block,
    input  logic              in_valid,
    output logic              in_ready,

    // Straight branch towards the processing part
    output mx_pkg::mx_block_t straight_block,
    output logic              straight_valid,
    input  logic              straight_ready,

    // Skip branch, buffered
    output mx_pkg::mx_block_t skip_block,
    output logic              skip_valid,
    input  logic              skip_ready
);

    logic fifo_in_valid;
    logic fifo_in_ready;

    // Both branches must take the block in the same edge
    assign in_ready       = fifo_in_ready && straight_ready;

    // Straight branch is combinational
    assign straight_block = in_block;
    assign straight_valid = in_valid && fifo_in_ready;

    // Push only when the straight side accepts too
    assign fifo_in_valid  = in_valid && straight_ready;

    mx_block_fifo skip_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_block  (in_block),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_block (skip_block),
        .out_valid (skip_valid),
        .out_ready (skip_ready)
    );

endmodule

// ==== mx_relu_norm.sv ====
`timescale 1ns/1ps

module mx_relu_norm (
    input  logic              clk,
    input  logic              rst,
    input  mx_pkg::mx_block_t in_block,
    input  logic              in_valid,
    output logic              in_ready,
    output mx_pkg::mx_block_t out_block,
    output logic              out_valid,
    input  logic              out_ready
);
    import mx_pkg::*;

    mx_block_t relu_block;
    mx_block_t norm_block;
    mx_block_t s1_block;
    mx_block_t s2_block;
    logic      s1_valid;
    logic      s2_valid;
    logic      s1_take;
    logic      s2_take;
    mantissa_t lane_max;
    shift_t    lz;
    shift_t    shift;

    // Leading zeros of a 7-bit magnitude, mag_width when all zero
    function automatic shift_t lead_zeros(input logic [mag_width-1:0] mag);
        shift_t n;
        logic   found;
        n     = shift_t'(mag_width);
        found = 1'b0;
        for (int b = mag_width - 1; b >= 0; b--) begin
            if (!found && mag[b]) begin
                n     = shift_t'(mag_width - 1 - b);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    assign s2_take   = s1_valid && (!s2_valid || out_ready);
    assign in_ready  = !s1_valid || s2_take;
    assign s1_take   = in_valid && in_ready;

    // Stage 1, negative lanes clamp to zero
    always_comb begin
        relu_block.exp = in_block.exp;
        for (int i = 0; i < block_size; i++) begin
            relu_block.man[i] = in_block.man[i][man_width-1] ? '0 : in_block.man[i];
        end
    end

    // Stage 2, scale so the largest lane fills the magnitude range
    always_comb begin
        lane_max = '0;
        for (int i = 0; i < block_size; i++) begin
            if (s1_block.man[i] > lane_max) begin
                lane_max = s1_block.man[i];
            end
        end
        lz = lead_zeros(lane_max[mag_width-1:0]);
        if (lane_max == '0) begin
            shift = '0;
        end else if (exponent_t'(lz) > s1_block.exp) begin
            // Exponent may not go below zero
            shift = shift_t'(s1_block.exp);
        end else begin
            shift = lz;
        end
        norm_block.exp = s1_block.exp - exponent_t'(shift);
        for (int i = 0; i < block_size; i++) begin
            norm_block.man[i] = s1_block.man[i] << shift;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_take) begin
            s1_block <= relu_block;
        end
        if (s2_take) begin
            s2_block <= norm_block;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                s1_valid <= in_valid;
            end
            if (!s2_valid || out_ready) begin
                s2_valid <= s1_valid;
            end
        end
    end

    assign out_block = s2_block;
    assign out_valid = s2_valid;

endmodule

// ==== mx_residual_add.sv ====
`timescale 1ns/1ps

module mx_residual_add (
    input  logic              clk,
    input  logic              rst,

    // Operand from the skip FIFO
    input  mx_pkg::mx_block_t skip_block,
    input  logic              skip_valid,
    output logic              skip_ready,

    // Operand from the processing part
    input  mx_pkg::mx_block_t proc_block,
    input  logic              proc_valid,
    output logic              proc_ready,

    output mx_pkg::mx_block_t out_block,
    output logic              out_valid,
    input  logic              out_ready
);
    import mx_pkg::*;

    logic                       fire;
    logic                       skip_larger;
    exponent_t                  exp_res;
    exponent_t                  exp_diff;
    mantissa_t [block_size-1:0] skip_aligned;
    mantissa_t [block_size-1:0] proc_aligned;
    sum_t                       sum [block_size];
    logic                       overflow;
    mx_block_t                  result;

    // Arithmetic right shift with truncation, wide shifts leave only the sign
    function automatic mantissa_t align(input mantissa_t m, input exponent_t d);
        if (d >= exponent_t'(man_width)) begin
            return m[man_width-1] ? '1 : '0;
        end
        return m >>> d;
    endfunction

    function automatic mantissa_t saturate(input sum_t s);
        if (s[man_width] != s[man_width-1]) begin
            return s[man_width] ? man_min : man_max;
        end
        return s[man_width-1:0];
    endfunction

    assign fire       = skip_valid && proc_valid && (!out_valid || out_ready);
    assign skip_ready = fire;
    assign proc_ready = fire;

    // Common exponent is the larger one
    assign skip_larger = skip_block.exp >= proc_block.exp;
    assign exp_res     = skip_larger ? skip_block.exp : proc_block.exp;
    assign exp_diff    = skip_larger ? skip_block.exp - proc_block.exp
                                     : proc_block.exp - skip_block.exp;

    always_comb begin
        overflow = 1'b0;
        for (int i = 0; i < block_size; i++) begin
            skip_aligned[i] = skip_larger ? skip_block.man[i]
                                          : align(skip_block.man[i], exp_diff);
            proc_aligned[i] = skip_larger ? align(proc_block.man[i], exp_diff)
                                          : proc_block.man[i];
            sum[i] = sum_t'($signed(skip_aligned[i])) + sum_t'($signed(proc_aligned[i]));
            if (sum[i][man_width] != sum[i][man_width-1]) begin
                overflow = 1'b1;
            end
        end
    end

    // One lane out of range rescales the whole block
    always_comb begin
        result.exp = exp_res;
        for (int i = 0; i < block_size; i++) begin
            result.man[i] = sum[i][man_width-1:0];
        end
        if (overflow && (exp_res != exp_max)) begin
            result.exp = exp_res + 1'b1;
            for (int i = 0; i < block_size; i++) begin
                result.man[i] = sum[i][man_width:1];
            end
        end else if (overflow) begin
            for (int i = 0; i < block_size; i++) begin
                result.man[i] = saturate(sum[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_block <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

// ==== mx_residual_top.sv ====
`timescale 1ns/1ps

module mx_residual_top (
    input  logic              clk,
    input  logic              rst,
    input  mx_pkg::mx_block_t in_block,
    input  logic              in_valid,
    output logic              in_ready,
    output mx_pkg::mx_block_t out_block,
    output logic              out_valid,
    input  logic              out_ready
);
    import mx_pkg::*;

    mx_block_t straight_block;
    logic      straight_valid;
    logic      straight_ready;
    mx_block_t skip_block;
    logic      skip_valid;
    logic      skip_ready;
    mx_block_t proc_block;
    logic      proc_valid;
    logic      proc_ready;

    mx_block_fork fork_i (
        .clk            (clk),
        .rst            (rst),
        .in_block       (in_block),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .straight_block (straight_block),
        .straight_valid (straight_valid),
        .straight_ready (straight_ready),
        .skip_block     (skip_block),
        .skip_valid     (skip_valid),
        .skip_ready     (skip_ready)
    );

    mx_relu_norm relu_norm_i (
        .clk       (clk),
        .rst       (rst),
        .in_block  (straight_block),
        .in_valid  (straight_valid),
        .in_ready  (straight_ready),
        .out_block (proc_block),
        .out_valid (proc_valid),
        .out_ready (proc_ready)
    );

    // out = x + relu(x)
    mx_residual_add add_i (
        .clk        (clk),
        .rst        (rst),
        .skip_block (skip_block),
        .skip_valid (skip_valid),
        .skip_ready (skip_ready),
        .proc_block (proc_block),
        .proc_valid (proc_valid),
        .proc_ready (proc_ready),
        .out_block  (out_block),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

// ==== mx_residual_props.sv ====
`timescale 1ns/1ps

module mx_residual_props (
    input logic              clk,
    input logic              rst,
    input logic              in_ready,
    input mx_pkg::mx_block_t out_block,
    input logic              out_valid,
    input logic              out_ready
);

    int assert_fails = 0;

    // A stalled output holds its block
    output_stable_a : assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_block)))
        else begin
            $error("output block changed while out_ready was low");
            assert_fails++;
        end

    handshake_known_a : assert property (@(posedge clk) disable iff (rst)
        !$isunknown(in_ready) && !$isunknown(out_valid))
        else begin
            $error("in_ready or out_valid unknown after reset");
            assert_fails++;
        end

    // Registered valids leave reset low
    reset_valid_a : assert property (@(posedge clk)
        rst |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            assert_fails++;
        end

endmodule

// ==== tb_mx_residual.sv ====
`timescale 1ns/1ps

module tb_mx_residual;
    import mx_pkg::*;

    localparam int num_entries    = 8;
    localparam int timeout_cycles = 200;

    typedef logic [$bits(mx_block_t)-1:0] word_t;

    logic      clk = 1'b0;
    logic      rst;
    mx_block_t in_block;
    logic      in_valid;
    logic      in_ready;
    mx_block_t out_block;
    logic      out_valid;
    logic      out_ready;

    mx_block_t stim_tab [num_entries];
    mx_block_t expect_tab [num_entries];
    int        errors;
    int        assert_errors;
    int        inputs_accepted;
    int        outputs_seen;
    logic      timed_out;

    mx_residual_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_block  (in_block),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_block (out_block),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    bind mx_residual_top mx_residual_props props_i (
        .clk       (clk),
        .rst       (rst),
        .in_ready  (in_ready),
        .out_block (out_block),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #50 clk = ~clk;

    function automatic mx_block_t pack_block(input int e, input int m0, input int m1,
                                             input int m2, input int m3, input int m4,
                                             input int m5, input int m6, input int m7);
        mx_block_t b;
        int        lanes [block_size];
        lanes = '{m0, m1, m2, m3, m4, m5, m6, m7};
        b.exp = exponent_t'(e);
        for (int i = 0; i < block_size; i++) begin
            b.man[i] = mantissa_t'(lanes[i]);
        end
        return b;
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("** Error @ %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Expected lane is 2m for m >= 0 and m otherwise with a block rescale on overflow
    task automatic load_table();
        stim_tab[0]   = pack_block(10, 12, 5, 3, 1, 0, 7, 9, 2);
        expect_tab[0] = pack_block(10, 24, 10, 6, 2, 0, 14, 18, 4);
        stim_tab[1]   = pack_block(20, -5, 17, -128, 30, -1, 0, 63, -64);
        expect_tab[1] = pack_block(20, -5, 34, -128, 60, -1, 0, 126, -64);
        stim_tab[2]   = pack_block(85, 0, 0, 0, 0, 0, 0, 0, 0);
        expect_tab[2] = pack_block(85, 0, 0, 0, 0, 0, 0, 0, 0);
        stim_tab[3]   = pack_block(30, 100, 10, -20, 3, -7, 0, 50, 1);
        expect_tab[3] = pack_block(31, 100, 10, -10, 3, -4, 0, 50, 1);
        // Lanes saturate at exponent 255
        stim_tab[4]   = pack_block(255, 127, 64, 63, -1, -128, 0, 5, -3);
        expect_tab[4] = pack_block(255, 127, 127, 126, -1, -128, 0, 10, -3);
        // Shift limited by a small exponent
        stim_tab[5]   = pack_block(2, 1, 0, 2, 0, 1, 0, 0, 3);
        expect_tab[5] = pack_block(2, 2, 0, 4, 0, 2, 0, 0, 6);
        stim_tab[6]   = pack_block(64, -1, -2, -3, -4, -100, -128, -50, -7);
        expect_tab[6] = pack_block(64, -1, -2, -3, -4, -100, -128, -50, -7);
        stim_tab[7]   = pack_block(127, 127, -127, 64, -65, 1, -1, 2, -2);
        expect_tab[7] = pack_block(128, 127, -64, 64, -33, 1, -1, 2, -1);
    endtask

    task automatic apply_reset();
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            if (c == 2) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_value(word_t'(out_valid), word_t'(1'b0), "out_valid high during reset");
        end
    endtask

    task automatic drive_inputs();
        int waited;
        @(posedge clk);
        for (int i = 0; i < num_entries && !timed_out; i++) begin
            in_block <= stim_tab[i];
            in_valid <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (!in_ready && !timed_out) begin
                // Only a stalled output may hold back the input
                check_value(word_t'(out_valid && !out_ready), word_t'(1'b1),
                            "in_ready low without a stalled output");
                waited++;
                if (waited > timeout_cycles) begin
                    $display("Timeout: input block %0d was never accepted", i);
                    timed_out = 1'b1;
                end
                @(negedge clk);
            end
            @(posedge clk);
            if (!timed_out) begin
                inputs_accepted++;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic collect_outputs();
        int idle;
        idle = 0;
        while (outputs_seen < num_entries && !timed_out) begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_value(word_t'(outputs_seen < inputs_accepted), word_t'(1'b1),
                            "output block ahead of its input");
                check_value(out_block, expect_tab[outputs_seen],
                            $sformatf("output block %0d", outputs_seen));
                outputs_seen++;
                idle = 0;
            end else begin
                idle++;
                if (idle > timeout_cycles) begin
                    $display("Timeout: output block %0d never arrived", outputs_seen);
                    timed_out = 1'b1;
                end
            end
        end
        // Nothing may follow the last block
        for (int c = 0; c < 10 && !timed_out; c++) begin
            @(negedge clk);
            check_value(word_t'(out_valid), word_t'(1'b0), "extra output block");
        end
    endtask

    initial begin
        void'($urandom(2585));
        forever begin
            @(posedge clk);
            out_ready <= ($urandom % 100) < 70;
        end
    end

    initial begin
        rst             = 1'b1;
        in_block        = '0;
        in_valid        = 1'b0;
        out_ready       = 1'b0;
        errors          = 0;
        assert_errors   = 0;
        inputs_accepted = 0;
        outputs_seen    = 0;
        timed_out       = 1'b0;
        load_table();
        apply_reset();
        fork
            drive_inputs();
            collect_outputs();
        join
        assert_errors = dut_i.props_i.assert_fails;
        $display("Blocks in %0d, out %0d, errors %0d, assertion errors %0d, timeouts %0d",
                 inputs_accepted, outputs_seen, errors, assert_errors, timed_out);
        if (errors == 0 && assert_errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
mx_pkg.sv
mx_block_fifo.sv
mx_block_fork.sv
mx_relu_norm.sv
mx_residual_add.sv
mx_residual_top.sv
mx_residual_props.sv
tb_mx_residual.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mx_residual
FILELIST  = build.f
BUILD_DIR = obj_dir
PASS_MSG  = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
